// ==== mul_params.svh ====
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// index width of the reservation station, 8 entries
`define MUL_RS_DEPTH 3

// width of a ROB tag
`define ROB_DEPTH 3

// snooped CDB lanes
`define CDB_SIZE 2

// multiplier lanes, fixed at two
`define MUL_LANES 2

`endif

// ==== rv32m_pkg.sv ====
package rv32m_pkg;

  // operand signedness for one multiply
  typedef enum logic [1:0] {
    mul_signed_signed     = 2'b00,
    mul_signed_unsigned   = 2'b01,
    mul_unsigned_unsigned = 2'b10
  } mul_type_t;

  // funct3 codes of the RV32M multiply group
  localparam logic [2:0] mul_funct3    = 3'd0;
  localparam logic [2:0] mulh_funct3   = 3'd1;
  localparam logic [2:0] mulhsu_funct3 = 3'd2;
  localparam logic [2:0] mulhu_funct3  = 3'd3;

  typedef struct packed {
    logic [31:0] hi;
    logic [31:0] lo;
  } mul_halves_t;

  // 64-bit product, seen whole or as two words
  typedef union packed {
    logic [63:0] full;
    mul_halves_t half;
  } mul_product_t;

endpackage

// ==== shift_add_multiplier.sv ====
module shift_add_multiplier
  import rv32m_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         start,
  input  mul_type_t    mul_type,
  input  logic [31:0]  a,
  input  logic [31:0]  b,
  output mul_product_t p,
  output logic         done,
  output logic         busy
);

  logic [4:0]  step_cnt;
  logic        neg;
  logic        a_neg;
  logic        b_neg;
  logic [31:0] a_mag;
  logic [31:0] b_mag;
  logic [63:0] acc;
  logic [63:0] acc_next;
  logic [63:0] mcand;
  logic [31:0] mplier;

  // a is signed for MULH and MULHSU, b only for MULH
  assign a_neg = (mul_type != mul_unsigned_unsigned) && a[31];
  assign b_neg = (mul_type == mul_signed_signed) && b[31];
  assign a_mag = a_neg ? -a : a;
  assign b_mag = b_neg ? -b : b;

  assign acc_next = mplier[0] ? acc + mcand : acc;

  // 32 steps, done on the 33rd cycle after start
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      step_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        step_cnt <= '0;
      end else if (busy) begin
        step_cnt <= step_cnt + 1'b1;
        if (step_cnt == 5'd31) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      neg <= a_neg ^ b_neg;
      acc <= '0;
      mcand <= {32'd0, a_mag};
      mplier <= b_mag;
    end else if (busy) begin
      acc <= acc_next;
      mcand <= mcand << 1;
      mplier <= mplier >> 1;
      // last step also fixes the sign
      if (step_cnt == 5'd31) begin
        p.full <= neg ? -acc_next : acc_next;
      end
    end
  end

endmodule

// ==== mul_result_merge.sv ====
`include "mul_params.svh"

module mul_result_merge
  import rv32m_pkg::*;
(
  input  logic                      lane_done [`MUL_LANES],
  input  mul_product_t              lane_p [`MUL_LANES],
  input  logic [2:0]                lane_funct3 [`MUL_LANES],
  input  logic [`ROB_DEPTH-1:0]     lane_rob [`MUL_LANES],
  input  logic [`MUL_RS_DEPTH-1:0]  lane_idx [`MUL_LANES],
  output logic                      mul_rs_valid,
  output logic [31:0]               mul_rs_p,
  output logic [`ROB_DEPTH-1:0]     mul_rs_rob,
  output logic                      pop,
  output logic [`MUL_RS_DEPTH-1:0]  pop_idx
);

  logic         any_done;
  mul_product_t sel_p;
  logic [2:0]   sel_funct3;

  // lanes never finish together, so the first done found is the only one
  always_comb begin
    any_done = 1'b0;
    sel_p = '0;
    sel_funct3 = mul_funct3;
    mul_rs_rob = '0;
    pop_idx = '0;
    for (int l = 0; l < `MUL_LANES; l++) begin
      if (!any_done && lane_done[l]) begin
        any_done = 1'b1;
        sel_p = lane_p[l];
        sel_funct3 = lane_funct3[l];
        mul_rs_rob = lane_rob[l];
        pop_idx = lane_idx[l];
      end
    end
  end

  // low word for MUL, high word for the MULH group
  always_comb begin
    if (!any_done) begin
      mul_rs_p = '0;
    end else if (sel_funct3 == mul_funct3) begin
      mul_rs_p = sel_p.half.lo;
    end else begin
      mul_rs_p = sel_p.half.hi;
    end
  end

  assign mul_rs_valid = any_done;
  // entry leaves the station as the result goes out
  assign pop = any_done;

endmodule

// ==== mul_rs.sv ====
`include "mul_params.svh"

module mul_rs
  import rv32m_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      mul_rs_issue,
  input  logic [6:0]                opcode,
  input  logic [2:0]                funct3,
  input  logic [6:0]                funct7,
  input  logic                      issue_rs1_regfile_ready,
  input  logic                      issue_rs2_regfile_ready,
  input  logic [31:0]               issue_rs1_regfile_v,
  input  logic [31:0]               issue_rs2_regfile_v,
  input  logic [`ROB_DEPTH-1:0]     issue_rs1_regfile_rob,
  input  logic [`ROB_DEPTH-1:0]     issue_rs2_regfile_rob,
  input  logic                      issue_rs1_rob_ready,
  input  logic                      issue_rs2_rob_ready,
  input  logic [31:0]               issue_rs1_rob_v,
  input  logic [31:0]               issue_rs2_rob_v,
  input  logic                      cdb_valid [`CDB_SIZE],
  input  logic [`ROB_DEPTH-1:0]     cdb_rob [`CDB_SIZE],
  input  logic [31:0]               cdb_rd_v [`CDB_SIZE],
  input  logic [`ROB_DEPTH-1:0]     issue_target_rob,
  input  logic                      lane_busy [`MUL_LANES],
  input  logic                      pop,
  input  logic [`MUL_RS_DEPTH-1:0]  pop_idx,
  output logic                      mul_rs_full,
  output logic                      lane_start [`MUL_LANES],
  output mul_type_t                 lane_type [`MUL_LANES],
  output logic [31:0]               lane_a [`MUL_LANES],
  output logic [31:0]               lane_b [`MUL_LANES],
  output logic [2:0]                lane_funct3 [`MUL_LANES],
  output logic [`ROB_DEPTH-1:0]     lane_rob [`MUL_LANES],
  output logic [`MUL_RS_DEPTH-1:0]  lane_idx [`MUL_LANES]
);

  localparam int IDX_W = `MUL_RS_DEPTH;
  localparam int RS_NUM = 1 << IDX_W;
  localparam int LANE_W = $clog2(`MUL_LANES);
  localparam logic [6:0] opcode_op = 7'b0110011;
  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  // entry state
  logic                  valid_arr [RS_NUM];
  logic                  inflight_arr [RS_NUM];
  logic                  rs1_ready_arr [RS_NUM];
  logic                  rs2_ready_arr [RS_NUM];
  logic [31:0]           rs1_v_arr [RS_NUM];
  logic [31:0]           rs2_v_arr [RS_NUM];
  logic [`ROB_DEPTH-1:0] rs1_rob_arr [RS_NUM];
  logic [`ROB_DEPTH-1:0] rs2_rob_arr [RS_NUM];
  logic [`ROB_DEPTH-1:0] target_rob_arr [RS_NUM];
  logic [2:0]            funct3_arr [RS_NUM];

  // snoop hits this cycle
  logic        rs1_hit [RS_NUM];
  logic        rs2_hit [RS_NUM];
  logic [31:0] rs1_cdb_v [RS_NUM];
  logic [31:0] rs2_cdb_v [RS_NUM];

  logic             issue_ok;
  logic             free_found;
  logic [IDX_W-1:0] free_idx;
  logic [IDX_W-1:0] rr_ptr;
  logic [IDX_W-1:0] scan_idx;
  logic             disp_found;
  logic [IDX_W-1:0] disp_idx;
  logic             lane_found;
  logic [LANE_W-1:0] lane_sel;
  logic             dispatch;
  mul_type_t        disp_type;

  // only MUL, MULH, MULHSU and MULHU are accepted
  assign issue_ok = mul_rs_issue && free_found && opcode == opcode_op
                    && funct7 == funct7_muldiv && !funct3[2];
  assign dispatch = disp_found && lane_found;
  assign mul_rs_full = !free_found;

  // lowest free entry
  always_comb begin
    free_found = 1'b0;
    free_idx = '0;
    for (int i = RS_NUM - 1; i >= 0; i--) begin
      if (!valid_arr[i]) begin
        free_found = 1'b1;
        free_idx = IDX_W'(i);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < RS_NUM; i++) begin
      rs1_hit[i] = 1'b0;
      rs2_hit[i] = 1'b0;
      rs1_cdb_v[i] = '0;
      rs2_cdb_v[i] = '0;
      for (int j = 0; j < `CDB_SIZE; j++) begin
        if (valid_arr[i] && !rs1_ready_arr[i] && cdb_valid[j] && cdb_rob[j] == rs1_rob_arr[i]) begin
          rs1_hit[i] = 1'b1;
          rs1_cdb_v[i] = cdb_rd_v[j];
        end
        if (valid_arr[i] && !rs2_ready_arr[i] && cdb_valid[j] && cdb_rob[j] == rs2_rob_arr[i]) begin
          rs2_hit[i] = 1'b1;
          rs2_cdb_v[i] = cdb_rd_v[j];
        end
      end
    end
  end

  // round robin search starting after the last freed entry
  always_comb begin
    disp_found = 1'b0;
    disp_idx = '0;
    scan_idx = rr_ptr;
    for (int k = 0; k < RS_NUM; k++) begin
      scan_idx = rr_ptr + IDX_W'(k);
      if (!disp_found && valid_arr[scan_idx] && !inflight_arr[scan_idx]
          && rs1_ready_arr[scan_idx] && rs2_ready_arr[scan_idx]) begin
        disp_found = 1'b1;
        disp_idx = scan_idx;
      end
    end
  end

  // a lane pulsing start is not busy yet, so count it as taken
  always_comb begin
    lane_found = 1'b0;
    lane_sel = '0;
    for (int l = 0; l < `MUL_LANES; l++) begin
      if (!lane_found && !lane_busy[l] && !lane_start[l]) begin
        lane_found = 1'b1;
        lane_sel = LANE_W'(l);
      end
    end
  end

  always_comb begin
    case (funct3_arr[disp_idx])
      mulhsu_funct3: disp_type = mul_signed_unsigned;
      mulhu_funct3:  disp_type = mul_unsigned_unsigned;
      default:       disp_type = mul_signed_signed;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr <= '0;
      for (int i = 0; i < RS_NUM; i++) begin
        valid_arr[i] <= 1'b0;
        inflight_arr[i] <= 1'b0;
        rs1_ready_arr[i] <= 1'b0;
        rs2_ready_arr[i] <= 1'b0;
      end
      for (int l = 0; l < `MUL_LANES; l++) begin
        lane_start[l] <= 1'b0;
      end
    end else begin
      for (int i = 0; i < RS_NUM; i++) begin
        if (rs1_hit[i]) begin
          rs1_ready_arr[i] <= 1'b1;
        end
        if (rs2_hit[i]) begin
          rs2_ready_arr[i] <= 1'b1;
        end
      end
      if (issue_ok) begin
        valid_arr[free_idx] <= 1'b1;
        inflight_arr[free_idx] <= 1'b0;
        rs1_ready_arr[free_idx] <= issue_rs1_regfile_ready || issue_rs1_rob_ready;
        rs2_ready_arr[free_idx] <= issue_rs2_regfile_ready || issue_rs2_rob_ready;
      end
      for (int l = 0; l < `MUL_LANES; l++) begin
        lane_start[l] <= 1'b0;
      end
      if (dispatch) begin
        lane_start[lane_sel] <= 1'b1;
        inflight_arr[disp_idx] <= 1'b1;
      end
      if (pop) begin
        valid_arr[pop_idx] <= 1'b0;
        inflight_arr[pop_idx] <= 1'b0;
        rr_ptr <= pop_idx + 1'b1;
      end
    end
  end

  // entry payload, regfile value wins over ROB value
  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_NUM; i++) begin
      if (rs1_hit[i]) begin
        rs1_v_arr[i] <= rs1_cdb_v[i];
      end
      if (rs2_hit[i]) begin
        rs2_v_arr[i] <= rs2_cdb_v[i];
      end
    end
    if (issue_ok) begin
      rs1_v_arr[free_idx] <= issue_rs1_regfile_ready ? issue_rs1_regfile_v : issue_rs1_rob_v;
      rs2_v_arr[free_idx] <= issue_rs2_regfile_ready ? issue_rs2_regfile_v : issue_rs2_rob_v;
      rs1_rob_arr[free_idx] <= issue_rs1_regfile_rob;
      rs2_rob_arr[free_idx] <= issue_rs2_regfile_rob;
      target_rob_arr[free_idx] <= issue_target_rob;
      funct3_arr[free_idx] <= funct3;
    end
  end

  // lane operands latched with the start pulse
  always_ff @(posedge clk) begin
    if (dispatch) begin
      lane_type[lane_sel] <= disp_type;
      lane_a[lane_sel] <= rs1_v_arr[disp_idx];
      lane_b[lane_sel] <= rs2_v_arr[disp_idx];
      lane_funct3[lane_sel] <= funct3_arr[disp_idx];
      lane_rob[lane_sel] <= target_rob_arr[disp_idx];
      lane_idx[lane_sel] <= disp_idx;
    end
  end

endmodule

// ==== mul_unit_top.sv ====
`include "mul_params.svh"

module mul_unit_top
  import rv32m_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   mul_rs_issue,
  input  logic [6:0]             opcode,
  input  logic [2:0]             funct3,
  input  logic [6:0]             funct7,
  input  logic                   issue_rs1_regfile_ready,
  input  logic                   issue_rs2_regfile_ready,
  input  logic [31:0]            issue_rs1_regfile_v,
  input  logic [31:0]            issue_rs2_regfile_v,
  input  logic [`ROB_DEPTH-1:0]  issue_rs1_regfile_rob,
  input  logic [`ROB_DEPTH-1:0]  issue_rs2_regfile_rob,
  input  logic                   issue_rs1_rob_ready,
  input  logic                   issue_rs2_rob_ready,
  input  logic [31:0]            issue_rs1_rob_v,
  input  logic [31:0]            issue_rs2_rob_v,
  input  logic                   cdb_valid [`CDB_SIZE],
  input  logic [`ROB_DEPTH-1:0]  cdb_rob [`CDB_SIZE],
  input  logic [31:0]            cdb_rd_v [`CDB_SIZE],
  input  logic [`ROB_DEPTH-1:0]  issue_target_rob,
  output logic                   mul_rs_full,
  output logic                   mul_rs_valid,
  output logic [31:0]            mul_rs_p,
  output logic [`ROB_DEPTH-1:0]  mul_rs_rob
);

  // station to lanes
  logic                     lane_start [`MUL_LANES];
  mul_type_t                lane_type [`MUL_LANES];
  logic [31:0]              lane_a [`MUL_LANES];
  logic [31:0]              lane_b [`MUL_LANES];
  logic [2:0]               lane_funct3 [`MUL_LANES];
  logic [`ROB_DEPTH-1:0]    lane_rob [`MUL_LANES];
  logic [`MUL_RS_DEPTH-1:0] lane_idx [`MUL_LANES];

  // lanes back to station and merger
  logic                     lane_busy [`MUL_LANES];
  logic                     lane_done [`MUL_LANES];
  mul_product_t             lane_p [`MUL_LANES];
  logic                     pop;
  logic [`MUL_RS_DEPTH-1:0] pop_idx;

  mul_rs mul_rs_inst (
    .clk(clk), .rst(rst), .mul_rs_issue(mul_rs_issue),
    .opcode(opcode), .funct3(funct3), .funct7(funct7),
    .issue_rs1_regfile_ready(issue_rs1_regfile_ready),
    .issue_rs2_regfile_ready(issue_rs2_regfile_ready),
    .issue_rs1_regfile_v(issue_rs1_regfile_v), .issue_rs2_regfile_v(issue_rs2_regfile_v),
    .issue_rs1_regfile_rob(issue_rs1_regfile_rob),
    .issue_rs2_regfile_rob(issue_rs2_regfile_rob),
    .issue_rs1_rob_ready(issue_rs1_rob_ready), .issue_rs2_rob_ready(issue_rs2_rob_ready),
    .issue_rs1_rob_v(issue_rs1_rob_v), .issue_rs2_rob_v(issue_rs2_rob_v),
    .cdb_valid(cdb_valid), .cdb_rob(cdb_rob), .cdb_rd_v(cdb_rd_v),
    .issue_target_rob(issue_target_rob),
    .lane_busy(lane_busy), .pop(pop), .pop_idx(pop_idx),
    .mul_rs_full(mul_rs_full), .lane_start(lane_start), .lane_type(lane_type),
    .lane_a(lane_a), .lane_b(lane_b), .lane_funct3(lane_funct3),
    .lane_rob(lane_rob), .lane_idx(lane_idx)
  );

  shift_add_multiplier lane0 (
    .clk(clk), .rst(rst), .start(lane_start[0]), .mul_type(lane_type[0]),
    .a(lane_a[0]), .b(lane_b[0]), .p(lane_p[0]), .done(lane_done[0]), .busy(lane_busy[0])
  );

  shift_add_multiplier lane1 (
    .clk(clk), .rst(rst), .start(lane_start[1]), .mul_type(lane_type[1]),
    .a(lane_a[1]), .b(lane_b[1]), .p(lane_p[1]), .done(lane_done[1]), .busy(lane_busy[1])
  );

  mul_result_merge mul_result_merge_inst (
    .lane_done(lane_done), .lane_p(lane_p), .lane_funct3(lane_funct3),
    .lane_rob(lane_rob), .lane_idx(lane_idx),
    .mul_rs_valid(mul_rs_valid), .mul_rs_p(mul_rs_p), .mul_rs_rob(mul_rs_rob),
    .pop(pop), .pop_idx(pop_idx)
  );

endmodule

// ==== mul_unit_chk.sv ====
`include "mul_params.svh"

module mul_unit_chk (
  input logic                  clk,
  input logic                  rst,
  input logic                  mul_rs_issue,
  input logic                  mul_rs_full,
  input logic                  mul_rs_valid,
  input logic [`ROB_DEPTH-1:0] mul_rs_rob
);

  // nothing leaves the unit right after a reset edge
  valid_after_reset: assert property (@(posedge clk) rst |=> !mul_rs_valid)
    else $error("mul_rs_valid high while in reset");

  // the station must have room for every issue
  issue_not_full: assert property (@(posedge clk) disable iff (rst)
    mul_rs_issue |-> !mul_rs_full)
    else $error("issue accepted while mul_rs_full is high");

  // lanes may finish back to back, but one result is a single cycle
  valid_one_cycle: assert property (@(posedge clk) disable iff (rst)
    mul_rs_valid |=> !(mul_rs_valid && mul_rs_rob == $past(mul_rs_rob)))
    else $error("result for the same tag held for more than one cycle");

endmodule

bind mul_unit_top mul_unit_chk mul_unit_chk_inst (.*);

// ==== mul_unit_tb.sv ====
`include "mul_params.svh"

module mul_unit_tb
  import rv32m_pkg::*;
();

  localparam int num_ops = 120;
  localparam int timeout_cycles = num_ops * 40 * 2 + 200;
  localparam int min_latency = 34;
  localparam int tags = 1 << `ROB_DEPTH;
  localparam int rs_entries = 1 << `MUL_RS_DEPTH;
  localparam logic [6:0] opcode_op = 7'b0110011;
  localparam logic [6:0] funct7_muldiv = 7'b0000001;
  // where an operand comes from at issue
  localparam int from_rf = 0;
  localparam int from_rob = 1;
  localparam int from_both = 2;
  localparam int wait_cdb = 3;

  logic                  clk;
  logic                  rst;
  logic                  mul_rs_issue;
  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic                  issue_rs1_regfile_ready;
  logic                  issue_rs2_regfile_ready;
  logic [31:0]           issue_rs1_regfile_v;
  logic [31:0]           issue_rs2_regfile_v;
  logic [`ROB_DEPTH-1:0] issue_rs1_regfile_rob;
  logic [`ROB_DEPTH-1:0] issue_rs2_regfile_rob;
  logic                  issue_rs1_rob_ready;
  logic                  issue_rs2_rob_ready;
  logic [31:0]           issue_rs1_rob_v;
  logic [31:0]           issue_rs2_rob_v;
  logic                  cdb_valid [`CDB_SIZE];
  logic [`ROB_DEPTH-1:0] cdb_rob [`CDB_SIZE];
  logic [31:0]           cdb_rd_v [`CDB_SIZE];
  logic [`ROB_DEPTH-1:0] issue_target_rob;
  logic                  mul_rs_full;
  logic                  mul_rs_valid;
  logic [31:0]           mul_rs_p;
  logic [`ROB_DEPTH-1:0] mul_rs_rob;

  // scoreboard, indexed by target tag
  logic                  pend [tags];
  logic [2:0]            exp_funct3 [tags];
  logic [31:0]           exp_a [tags];
  logic [31:0]           exp_b [tags];
  logic                  wait_a [tags];
  logic                  wait_b [tags];
  logic [`ROB_DEPTH-1:0] src_a [tags];
  logic [`ROB_DEPTH-1:0] src_b [tags];
  int                    issue_cyc [tags];
  // value each producer tag puts on the CDB
  logic [31:0]           cdb_val [tags];
  logic [31:0]           corner [4];
  int                    result_cyc [$];
  int                    outstanding = 0;
  int                    cyc = 0;
  int                    mismatches = 0;
  int                    failures = 0;
  int                    results = 0;

  mul_unit_top mul_unit_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // RV32M product, operands widened by funct3
  function automatic logic [31:0] expected_result(input logic [2:0] f3, input logic [31:0] a,
                                                  input logic [31:0] b);
    logic [63:0] wa;
    logic [63:0] wb;
    logic [63:0] prod;
    wa = (f3 == mulh_funct3 || f3 == mulhsu_funct3) ? {{32{a[31]}}, a} : {32'd0, a};
    wb = (f3 == mulh_funct3) ? {{32{b[31]}}, b} : {32'd0, b};
    prod = wa * wb;
    return (f3 == mul_funct3) ? prod[31:0] : prod[63:32];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t signal=%s got=0x%08h expected=0x%08h", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("ERROR time=%0t %s", $time, msg);
    failures++;
  endtask

  task automatic print_counts();
    $display("errors: mismatches=%0d other=%0d results=%0d", mismatches, failures, results);
  endtask

  task automatic issue_op(input logic [2:0] f3, input int a_mode, input logic [31:0] a_val,
                          input logic [`ROB_DEPTH-1:0] a_src, input int b_mode,
                          input logic [31:0] b_val, input logic [`ROB_DEPTH-1:0] b_src);
    int tag;
    @(posedge clk);
    while (outstanding >= rs_entries) begin
      mul_rs_issue <= 1'b0;
      @(posedge clk);
    end
    tag = 0;
    while (pend[tag]) begin
      tag++;
    end
    pend[tag] = 1'b1;
    exp_funct3[tag] = f3;
    exp_a[tag] = (a_mode == wait_cdb) ? cdb_val[a_src] : a_val;
    exp_b[tag] = (b_mode == wait_cdb) ? cdb_val[b_src] : b_val;
    wait_a[tag] = (a_mode == wait_cdb);
    wait_b[tag] = (b_mode == wait_cdb);
    src_a[tag] = a_src;
    src_b[tag] = b_src;
    issue_cyc[tag] = cyc;
    outstanding++;
    mul_rs_issue <= 1'b1;
    opcode <= opcode_op;
    funct3 <= f3;
    funct7 <= funct7_muldiv;
    issue_target_rob <= tag[`ROB_DEPTH-1:0];
    // the source that must not win carries the inverted value
    issue_rs1_regfile_ready <= (a_mode == from_rf || a_mode == from_both);
    issue_rs1_rob_ready <= (a_mode == from_rob || a_mode == from_both);
    issue_rs1_regfile_v <= (a_mode == from_rob) ? ~a_val : a_val;
    issue_rs1_rob_v <= (a_mode == from_rob) ? a_val : ~a_val;
    issue_rs1_regfile_rob <= a_src;
    issue_rs2_regfile_ready <= (b_mode == from_rf || b_mode == from_both);
    issue_rs2_rob_ready <= (b_mode == from_rob || b_mode == from_both);
    issue_rs2_regfile_v <= (b_mode == from_rob) ? ~b_val : b_val;
    issue_rs2_rob_v <= (b_mode == from_rob) ? b_val : ~b_val;
    issue_rs2_regfile_rob <= b_src;
    cdb_valid[0] <= 1'b0;
    cdb_valid[1] <= 1'b0;
  endtask

  task automatic broadcast(input logic v0, input logic [`ROB_DEPTH-1:0] t0,
                           input logic v1, input logic [`ROB_DEPTH-1:0] t1);
    @(posedge clk);
    mul_rs_issue <= 1'b0;
    cdb_valid[0] <= v0;
    cdb_rob[0] <= t0;
    cdb_rd_v[0] <= cdb_val[t0];
    cdb_valid[1] <= v1;
    cdb_rob[1] <= t1;
    cdb_rd_v[1] <= cdb_val[t1];
    for (int t = 0; t < tags; t++) begin
      if (pend[t] && ((v0 && src_a[t] == t0) || (v1 && src_a[t] == t1))) begin
        wait_a[t] = 1'b0;
      end
      if (pend[t] && ((v0 && src_b[t] == t0) || (v1 && src_b[t] == t1))) begin
        wait_b[t] = 1'b0;
      end
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      mul_rs_issue <= 1'b0;
      cdb_valid[0] <= 1'b0;
      cdb_valid[1] <= 1'b0;
    end
  endtask

  task automatic drain_results();
    idle(1);
    wait (outstanding == 0);
  endtask

  // compare each result against the scoreboard
  always @(negedge clk) begin
    if (rst) begin
      if (mul_rs_valid === 1'b1) begin
        report_failure("mul_rs_valid high during reset");
      end
    end else begin
      if (mul_rs_issue && mul_rs_full) begin
        report_failure("issue while the station is full");
      end
      if (mul_rs_valid) begin
        if (!pend[mul_rs_rob]) begin
          report_failure($sformatf("result for tag %0d that is not in flight", mul_rs_rob));
        end else begin
          if (wait_a[mul_rs_rob] || wait_b[mul_rs_rob]) begin
            report_failure($sformatf("tag %0d finished before its operands were broadcast",
                                     mul_rs_rob));
          end
          if (cyc - issue_cyc[mul_rs_rob] < min_latency) begin
            report_failure($sformatf("tag %0d finished too soon after issue", mul_rs_rob));
          end
          check_value($sformatf("mul_rs_p rob=%0d", mul_rs_rob), mul_rs_p,
                      expected_result(exp_funct3[mul_rs_rob], exp_a[mul_rs_rob],
                                      exp_b[mul_rs_rob]));
          pend[mul_rs_rob] = 1'b0;
          outstanding--;
          results++;
          result_cyc.push_back(cyc);
        end
      end
    end
  end

  initial begin
    wait (cyc >= timeout_cycles);
    report_failure($sformatf("timeout with %0d results still missing", outstanding));
    print_counts();
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    int base;
    rst = 1'b1;
    mul_rs_issue = 1'b0;
    opcode = '0;
    funct3 = '0;
    funct7 = '0;
    issue_rs1_regfile_ready = 1'b0;
    issue_rs2_regfile_ready = 1'b0;
    issue_rs1_regfile_v = '0;
    issue_rs2_regfile_v = '0;
    issue_rs1_regfile_rob = '0;
    issue_rs2_regfile_rob = '0;
    issue_rs1_rob_ready = 1'b0;
    issue_rs2_rob_ready = 1'b0;
    issue_rs1_rob_v = '0;
    issue_rs2_rob_v = '0;
    issue_target_rob = '0;
    for (int l = 0; l < `CDB_SIZE; l++) begin
      cdb_valid[l] = 1'b0;
      cdb_rob[l] = '0;
      cdb_rd_v[l] = '0;
    end
    void'($urandom(32'hd760_d109));
    for (int t = 0; t < tags; t++) begin
      pend[t] = 1'b0;
      wait_a[t] = 1'b0;
      wait_b[t] = 1'b0;
      cdb_val[t] = $urandom();
    end
    corner[0] = 32'h8000_0000;
    corner[1] = 32'hffff_ffff;
    corner[2] = 32'h0000_0000;
    corner[3] = 32'h0000_0001;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    idle(2);

    // all four operations, corner pairs then random
    for (int f = 0; f < 4; f++) begin
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          issue_op(3'(f), from_rf, corner[i], 3'd0, from_rf, corner[j], 3'd0);
        end
      end
      for (int r = 0; r < 4; r++) begin
        issue_op(3'(f), from_rf, $urandom(), 3'd0, from_rf, $urandom(), 3'd0);
      end
    end
    drain_results();

    // ROB only, or both sources ready with regfile winning
    for (int i = 0; i < 8; i++) begin
      issue_op(3'($urandom() % 4), (i % 2 == 0) ? from_rob : from_both, $urandom(), 3'd0,
               (i % 4 < 2) ? from_both : from_rob, $urandom(), 3'd0);
    end
    drain_results();

    // operands arrive over the CDB, some lanes in the same cycle
    for (int i = 0; i < 8; i++) begin
      issue_op(3'(i % 4), wait_cdb, 32'd0, 3'(i), (i % 2 == 0) ? wait_cdb : from_rf,
               $urandom(), 3'((i + 3) % 8));
    end
    idle(40);
    broadcast(1'b1, 3'd0, 1'b1, 3'd1);
    idle(3);
    broadcast(1'b0, 3'd0, 1'b1, 3'd2);
    broadcast(1'b1, 3'd3, 1'b0, 3'd0);
    idle(5);
    broadcast(1'b1, 3'd4, 1'b1, 3'd5);
    idle(10);
    broadcast(1'b1, 3'd6, 1'b0, 3'd0);
    broadcast(1'b0, 3'd0, 1'b1, 3'd7);
    drain_results();

    // fill all eight entries, then free one and refill
    for (int i = 0; i < 8; i++) begin
      issue_op(3'(i % 4), wait_cdb, 32'd0, 3'(i), wait_cdb, 32'd0, 3'(7 - i));
    end
    idle(1);
    @(negedge clk);
    check_value("mul_rs_full", 32'(mul_rs_full), 32'd1);
    for (int k = 0; k < 4; k++) begin
      broadcast(1'b1, 3'(2 * k), 1'b1, 3'(2 * k + 1));
    end
    idle(1);
    wait (outstanding < rs_entries);
    @(negedge clk);
    check_value("mul_rs_full", 32'(mul_rs_full), 32'd0);
    for (int i = 0; i < 8; i++) begin
      issue_op(3'($urandom() % 4), from_rf, $urandom(), 3'd0, from_rob, $urandom(), 3'd0);
    end
    drain_results();

    // back to back burst, two lanes overlap
    base = result_cyc.size();
    for (int i = 0; i < 8; i++) begin
      issue_op(3'($urandom() % 4), from_rf, $urandom(), 3'd0, from_rf, $urandom(), 3'd0);
    end
    drain_results();
    if (result_cyc[base + 1] - result_cyc[base] >= 33) begin
      report_failure("second burst result came too late, the lanes did not overlap");
    end

    if (results != num_ops) begin
      report_failure($sformatf("saw %0d results for %0d operations", results, num_ops));
    end
    print_counts();
    if (mismatches + failures == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+.
rv32m_pkg.sv
shift_add_multiplier.sv
mul_result_merge.sv
mul_rs.sv
mul_unit_top.sv
mul_unit_chk.sv
mul_unit_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = mul_unit_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
